// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_idma
FLIST     := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
verilog/idma_pkg.sv
verilog/idma_buffer.sv
verilog/idma_regfile.sv
verilog/idma_rd_engine.sv
verilog/idma_top.sv
verification/tb_idma.sv

// File: verification/idma_vectors.txt
# cmd fields, all hex: T name | W addr data exp_err | R addr exp_data exp_err | P
# E err_addr | B first_idx count | I exp_irq
T regs_readback
R 00C 00000000 0
W 004 12345678 0
R 004 12345678 0
W 008 00000028 0
R 008 00000028 0
W 000 00000002 0
R 000 00000002 0
T aligned_40_beats
W 004 00010000 0
W 000 00000001 0
P
R 00C 00000002 0
B 0 28
W 00C 00000002 0
T split_at_4k
W 004 00001FE0 0
W 008 00000014 0
W 000 00000001 0
P
B 0 14
W 00C 00000002 0
T busy_start_and_unmapped
W 004 20000100 0
W 008 00000030 0
W 000 00000001 0
W 000 00000001 1
R 010 00000000 1
P
R 00C 00000002 0
B 0 30
W 00C 00000002 0
T resp_error_and_irq
E 30000F80
W 004 30000F40 0
W 008 00000020 0
W 000 00000003 0
P
R 00C 00000006 0
I 1
W 00C 00000006 0
R 00C 00000000 0
I 0
B 0 20

// File: verification/tb_idma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_idma;
    import idma_pkg::*;

    localparam int          AXI_AW         = 32;
    localparam int          ID_WIDTH       = 8;
    localparam int          BUF_AW         = 6;
    localparam int          MAX_BURST      = 16;
    localparam int          CYCLES_PER_VEC = 2000;
    localparam logic [31:0] RDATA_XOR      = 32'h5a5a0000;
    localparam logic [1:0]  RESP_SLVERR    = 2'b10;

    logic                  aclk = 1'b0;
    logic                  i_rst;
    logic                  i_psel;
    logic                  i_penable;
    logic                  i_pwrite;
    logic [APB_AW-1:0]     i_paddr;
    word_t                 i_pwdata;
    logic                  o_pready;
    word_t                 o_prdata;
    logic                  o_pslverr;
    logic                  o_arvalid;
    logic [ID_WIDTH-1:0]   o_arid;
    logic [AXI_AW-1:0]     o_araddr;
    logic [7:0]            o_arlen;
    logic [2:0]            o_arsize;
    logic [1:0]            o_arburst;
    logic                  i_arready = 1'b0;
    logic                  i_rvalid  = 1'b0;
    word_t                 i_rdata   = '0;
    logic [1:0]            i_rresp   = 2'b00;
    logic                  i_rlast   = 1'b0;
    logic                  o_rready;
    logic                  o_irq;

    // slave model state
    logic [31:0] lcg_state = 32'h2fa41dca;
    logic        r_active  = 1'b0;
    logic        r_acc     = 1'b0;
    logic [31:0] r_addr    = '0;
    int          r_left    = 0;
    logic [31:0] err_addr  = 32'hffff_fffc;
    logic [31:0] ar_addr_q[$];
    logic [7:0]  ar_len_q[$];

    // vector run state
    string       vec_q[$];
    int          n_vec = 0;
    string       test_name = "reset";
    logic [31:0] cfg_src = '0;
    int          cfg_num = 0;

    idma_top #(
        .AXI_AW    (AXI_AW),
        .ID_WIDTH  (ID_WIDTH),
        .BUF_AW    (BUF_AW),
        .MAX_BURST (MAX_BURST)
    ) DUT (
        .aclk      (aclk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_pready  (o_pready),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .o_arvalid (o_arvalid),
        .o_arid    (o_arid),
        .o_araddr  (o_araddr),
        .o_arlen   (o_arlen),
        .o_arsize  (o_arsize),
        .o_arburst (o_arburst),
        .i_arready (i_arready),
        .i_rvalid  (i_rvalid),
        .i_rdata   (i_rdata),
        .i_rresp   (i_rresp),
        .i_rlast   (i_rlast),
        .o_rready  (o_rready),
        .o_irq     (o_irq)
    );

    // 10 ns clock
    always #5 aclk = ~aclk;

    // ========================================
    // helpers
    // ========================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ready about three cycles in four
    function automatic logic draw_ready();
        logic [31:0] r;
        r = lcg_next();
        return r[31:30] != 2'b00;
    endfunction

    task automatic abort_run(input string why);
        $display("%s (test %s)", why, test_name);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // one apb transfer, setup then access until pready
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waits;
        waits = 0;
        @(negedge aclk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge aclk);
        i_penable = 1'b1;
        // sampled at the completing edge
        do begin
            @(posedge aclk);
            waits++;
        end while (!o_pready && waits < 8);
        if (!o_pready) begin
            abort_run("apb transfer got no pready within 8 cycles");
        end
        rdata = o_prdata;
        err   = o_pslverr;
        @(negedge aclk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        st = '0;
        while (st[1] !== 1'b1) begin
            apb_xfer(1'b0, REG_STATUS, '0, st, err);
        end
    endtask

    // replay the splitting rules over the recorded ar requests
    task automatic check_bursts();
        logic [31:0] addr;
        int          left;
        int          room;
        int          beats;
        addr = cfg_src;
        left = cfg_num;
        foreach (ar_addr_q[i]) begin
            // beats left in the current 4 KB page
            room  = (BYTES_4K - int'(addr[11:0])) / 4;
            beats = left;
            if (beats > MAX_BURST) begin
                beats = MAX_BURST;
            end
            if (beats > room) begin
                beats = room;
            end
            check_value("burst address", addr, ar_addr_q[i]);
            check_value("burst arlen", 32'(beats - 1), 32'(ar_len_q[i]));
            addr = addr + 32'(beats * 4);
            left = left - beats;
        end
        check_value("beats never requested", 32'd0, 32'(left));
        check_value("arid", 32'd0, 32'(o_arid));
        check_value("arsize", 32'd2, 32'(o_arsize));
        check_value("arburst", 32'd1, 32'(o_arburst));
        ar_addr_q.delete();
        ar_len_q.delete();
    endtask

    // buffer word i holds the beat from src + 4*i
    task automatic check_buffer(input int first, input int count);
        logic [31:0] rd;
        logic        err;
        logic [31:0] exp;
        for (int i = first; i < first + count; i++) begin
            apb_xfer(1'b0, BUF_WIN | APB_AW'(i * 4), '0, rd, err);
            exp = (cfg_src + 32'(i * 4)) ^ RDATA_XOR;
            check_value($sformatf("buffer word %0d", i), exp, rd);
            check_value("buffer read pslverr", 32'd0, 32'(err));
        end
    endtask

    // outputs that must be low straight after reset
    task automatic check_reset_outputs();
        check_value("arvalid after reset", 32'd0, 32'(o_arvalid));
        check_value("rready after reset", 32'd0, 32'(o_rready));
        check_value("irq after reset", 32'd0, 32'(o_irq));
        check_value("pready after reset", 32'd0, 32'(o_pready));
        check_value("pslverr after reset", 32'd0, 32'(o_pslverr));
    endtask

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen("verification/idma_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/idma_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                vec_q.push_back(line);
            end
        end
        $fclose(fd);
        n_vec = vec_q.size();
    endtask

    // ========================================
    // axi read slave model
    // ========================================
    always @(negedge aclk) begin
        // retire the beat taken at the last rising edge
        if (r_acc) begin
            r_addr = r_addr + 32'd4;
            r_left = r_left - 1;
            if (r_left == 0) begin
                r_active = 1'b0;
            end
        end
        // an offered beat stays until taken
        if (r_active && ((i_rvalid && !r_acc) || draw_ready())) begin
            i_rvalid = 1'b1;
            i_rdata  = r_addr ^ RDATA_XOR;
            i_rresp  = (r_addr == err_addr) ? RESP_SLVERR : 2'b00;
            i_rlast  = (r_left == 1);
        end else begin
            i_rvalid = 1'b0;
            i_rlast  = 1'b0;
        end
        r_acc = i_rvalid && o_rready;
        // address taken only between bursts
        if (o_arvalid && !r_active && draw_ready()) begin
            i_arready = 1'b1;
            ar_addr_q.push_back(o_araddr);
            ar_len_q.push_back(o_arlen);
            r_active  = 1'b1;
            r_addr    = o_araddr;
            r_left    = int'(o_arlen) + 1;
        end else begin
            i_arready = 1'b0;
        end
    end

    // ========================================
    // vector interpreter
    // ========================================
    initial begin
        string       line;
        string       cmd;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] rd;
        logic        err;
        i_rst     = 1'b1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        load_vectors();
        repeat (16) @(negedge aclk);
        i_rst = 1'b0;
        check_reset_outputs();
        foreach (vec_q[n]) begin
            line = vec_q[n];
            a0 = '0;
            a1 = '0;
            a2 = '0;
            void'($sscanf(line, "%s %h %h %h", cmd, a0, a1, a2));
            case (cmd)
                "T": void'($sscanf(line, "%s %s", cmd, test_name));
                "W": begin
                    apb_xfer(1'b1, a0[APB_AW-1:0], a1, rd, err);
                    check_value("write pslverr", a2, 32'(err));
                    if (a0[APB_AW-1:0] == REG_SRC) begin
                        cfg_src = a1;
                    end
                    if (a0[APB_AW-1:0] == REG_NUM) begin
                        cfg_num = int'(a1);
                    end
                end
                "R": begin
                    apb_xfer(1'b0, a0[APB_AW-1:0], '0, rd, err);
                    check_value("read data", a1, rd);
                    check_value("read pslverr", a2, 32'(err));
                end
                "P": begin
                    wait_done();
                    check_bursts();
                end
                "E": err_addr = a0;
                "B": check_buffer(int'(a0), int'(a1));
                "I": begin
                    @(negedge aclk);
                    check_value("irq level", a0, 32'(o_irq));
                end
                default: abort_run($sformatf("unknown vector command %s", cmd));
            endcase
        end
        $display("PASS: all tests");
        $finish;
    end

    // watchdog scaled to the vector count
    initial begin
        wait (n_vec > 0);
        repeat (n_vec * CYCLES_PER_VEC) @(posedge aclk);
        $display("timeout: vectors did not finish in %0d cycles", n_vec * CYCLES_PER_VEC);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog/idma_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module idma_buffer #(
    parameter int BUF_AW = 6
) (
    input  logic                 aclk,
    // write port, from the read engine
    input  logic                 i_we,
    input  logic [BUF_AW-1:0]    i_waddr,
    input  idma_pkg::word_t      i_wdata,
    // read port, from the apb window
    input  logic                 i_re,
    input  logic [BUF_AW-1:0]    i_raddr,
    output idma_pkg::word_t      o_rdata
);
    import idma_pkg::*;

    localparam int DEPTH = 2 ** BUF_AW;

    word_t mem [0:DEPTH-1];

    // one word per accepted beat
    always_ff @(posedge aclk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, data one cycle after i_re
    always_ff @(posedge aclk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

    // apb must not read a word the engine is filling right now
    a_no_rw_same_idx: assert property (@(posedge aclk)
        !(i_we && i_re && (i_waddr == i_raddr)));

endmodule

`default_nettype wire

// File: verilog/idma_pkg.sv
`default_nettype none

package idma_pkg;

    // data path, shared by axi read data and apb
    localparam int DATA_W = 32;
    typedef logic [DATA_W-1:0] word_t;

    // apb address width
    localparam int APB_AW = 12;

    // ========================================
    // register map
    // ========================================
    // ctrl: bit 0 start, bit 1 irq enable
    localparam logic [APB_AW-1:0] REG_CTRL   = 'h000;
    localparam logic [APB_AW-1:0] REG_SRC    = 'h004;
    localparam logic [APB_AW-1:0] REG_NUM    = 'h008;
    // status: bit 0 busy, bit 1 done, bit 2 resp error
    localparam logic [APB_AW-1:0] REG_STATUS = 'h00C;
    // buffer read window, selected by paddr bit 11
    localparam logic [APB_AW-1:0] BUF_WIN    = 'h800;

    // axi codes
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [1:0] RESP_OKAY      = 2'b00;

    // page size that no burst may cross
    localparam int BYTES_4K = 4096;

endpackage

`default_nettype wire

// File: verilog/idma_rd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module idma_rd_engine #(
    parameter int AXI_AW    = 32,
    parameter int ID_WIDTH  = 8,
    parameter int BUF_AW    = 6,
    parameter int MAX_BURST = 16
) (
    input  logic                  aclk,
    input  logic                  i_rst,
    // transfer request
    input  logic                  i_start_pulse,
    input  logic [AXI_AW-1:0]     i_src_addr,
    input  logic [BUF_AW:0]       i_beat_num,
    output logic                  o_busy,
    output logic                  o_done_pulse,
    output logic                  o_err_pulse,
    // axi read address
    output logic                  o_arvalid,
    output logic [ID_WIDTH-1:0]   o_arid,
    output logic [AXI_AW-1:0]     o_araddr,
    output logic [7:0]            o_arlen,
    output logic [2:0]            o_arsize,
    output logic [1:0]            o_arburst,
    input  logic                  i_arready,
    // axi read data
    input  logic                  i_rvalid,
    input  idma_pkg::word_t       i_rdata,
    input  logic [1:0]            i_rresp,
    input  logic                  i_rlast,
    output logic                  o_rready,
    // buffer write port
    output logic                  o_buf_we,
    output logic [BUF_AW-1:0]     o_buf_waddr,
    output idma_pkg::word_t       o_buf_wdata
);
    import idma_pkg::*;

    // wide enough for a full page of beats and any buffer depth
    localparam int CNT_W = 16;
    localparam int K4_AW = $clog2(BYTES_4K);
    localparam int PG_W  = K4_AW + 1;
    localparam int LSB   = $clog2(DATA_W / 8);

    logic [AXI_AW-1:0] next_addr;
    logic [BUF_AW:0]   remain;
    logic [BUF_AW-1:0] widx;
    logic [CNT_W-1:0]  to_4k;
    logic [CNT_W-1:0]  burst_beats;
    logic              start_ok;
    logic              ar_hs;
    logic              beat_ok;
    logic              last_ok;

    // ========================================
    // burst sizing
    // ========================================
    // beats left before the next page edge
    assign to_4k = CNT_W'(BYTES_4K >> LSB) - CNT_W'(next_addr[K4_AW-1:LSB]);

    // smallest of remaining, max burst and page room
    always_comb begin
        burst_beats = CNT_W'(remain);
        if (burst_beats > CNT_W'(MAX_BURST)) begin
            burst_beats = CNT_W'(MAX_BURST);
        end
        if (burst_beats > to_4k) begin
            burst_beats = to_4k;
        end
    end

    assign o_araddr  = next_addr;
    assign o_arlen   = 8'(burst_beats - CNT_W'(1));
    assign o_arid    = '0;
    assign o_arsize  = AXI_SIZE_WORD;
    assign o_arburst = AXI_BURST_INCR;

    assign start_ok = i_start_pulse && !o_busy;
    assign ar_hs    = o_arvalid && i_arready;
    assign beat_ok  = o_rready && i_rvalid;
    assign last_ok  = beat_ok && i_rlast;

    // every accepted beat lands in the buffer
    assign o_buf_we    = beat_ok;
    assign o_buf_waddr = widx;
    assign o_buf_wdata = i_rdata;

    // ========================================
    // control
    // ========================================
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            o_busy       <= 1'b0;
            o_arvalid    <= 1'b0;
            o_rready     <= 1'b0;
            o_done_pulse <= 1'b0;
            o_err_pulse  <= 1'b0;
        end else begin
            o_done_pulse <= last_ok && (remain == '0);
            o_err_pulse  <= beat_ok && (i_rresp != RESP_OKAY);
            if (start_ok) begin
                o_busy    <= 1'b1;
                o_arvalid <= 1'b1;
            end
            // one burst outstanding at a time
            if (ar_hs) begin
                o_arvalid <= 1'b0;
                o_rready  <= 1'b1;
            end
            if (last_ok) begin
                o_rready <= 1'b0;
                if (remain == '0) begin
                    o_busy <= 1'b0;
                end else begin
                    o_arvalid <= 1'b1;
                end
            end
        end
    end

    // address, count and write index
    always_ff @(posedge aclk) begin
        if (start_ok) begin
            next_addr <= i_src_addr;
            remain    <= i_beat_num;
            widx      <= '0;
        end
        if (ar_hs) begin
            next_addr <= next_addr + (AXI_AW'(burst_beats) << LSB);
            remain    <= remain - burst_beats[BUF_AW:0];
        end
        if (beat_ok) begin
            widx <= widx + 1'b1;
        end
    end

    a_ar_stable: assert property (@(posedge aclk) disable iff (i_rst)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr) && $stable(o_arlen));

    // last beat of an issued burst stays in the first beat's page
    a_no_4k_cross: assert property (@(posedge aclk) disable iff (i_rst)
        ar_hs |-> (PG_W'(o_araddr[K4_AW-1:0]) + (PG_W'(o_arlen) << LSB)) < PG_W'(BYTES_4K));

endmodule

`default_nettype wire

// File: verilog/idma_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module idma_regfile #(
    parameter int AXI_AW = 32,
    parameter int BUF_AW = 6
) (
    input  logic                         aclk,
    input  logic                         i_rst,
    // apb slave
    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic                         i_pwrite,
    input  logic [idma_pkg::APB_AW-1:0]  i_paddr,
    input  idma_pkg::word_t              i_pwdata,
    output logic                         o_pready,
    output idma_pkg::word_t              o_prdata,
    output logic                         o_pslverr,
    // engine side
    input  logic                         i_busy,
    input  logic                         i_done_pulse,
    input  logic                         i_err_pulse,
    output logic                         o_start_pulse,
    output logic [AXI_AW-1:0]            o_src_addr,
    output logic [BUF_AW:0]              o_beat_num,
    // buffer read port
    output logic                         o_buf_re,
    output logic [BUF_AW-1:0]            o_buf_raddr,
    input  idma_pkg::word_t              i_buf_rdata,
    output logic                         o_irq
);
    import idma_pkg::*;

    logic  access;
    logic  win_sel;
    logic  win_pend;
    logic  reg_hit;
    logic  start_req;
    logic  start_err;
    logic  wr_en;
    logic  irq_en;
    logic  done_q;
    logic  err_q;
    word_t reg_rdata;

    // ========================================
    // apb decode
    // ========================================
    assign access  = i_psel && i_penable;
    assign win_sel = (i_paddr & BUF_WIN) == BUF_WIN;

    // register read mux, also flags unmapped offsets
    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (i_paddr)
            REG_CTRL:   reg_rdata = {{(DATA_W-2){1'b0}}, irq_en, 1'b0};
            REG_SRC:    reg_rdata = word_t'(o_src_addr);
            REG_NUM:    reg_rdata = word_t'(o_beat_num);
            REG_STATUS: reg_rdata = word_t'({err_q, done_q, i_busy});
            default:    reg_hit = 1'b0;
        endcase
    end

    // start only from idle, a pulse already in flight counts as busy
    assign start_req = access && i_pwrite && !win_sel && (i_paddr == REG_CTRL) && i_pwdata[0];
    assign start_err = start_req && (i_busy || o_start_pulse);
    assign wr_en     = access && i_pwrite && !win_sel && !start_err;

    // window read: first access cycle fetches, second completes
    assign o_buf_re    = access && win_sel && !i_pwrite && !win_pend;
    assign o_buf_raddr = i_paddr[BUF_AW+1:2];

    assign o_pready  = access && (!win_sel || i_pwrite || win_pend);
    assign o_pslverr = o_pready && ((!win_sel && !reg_hit) || start_err);
    assign o_prdata  = win_sel ? i_buf_rdata : reg_rdata;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            win_pend <= 1'b0;
        end else begin
            win_pend <= o_buf_re;
        end
    end

    // ========================================
    // registers
    // ========================================
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            o_start_pulse <= 1'b0;
            irq_en        <= 1'b0;
            o_src_addr    <= '0;
            o_beat_num    <= '0;
            done_q        <= 1'b0;
            err_q         <= 1'b0;
            o_irq         <= 1'b0;
        end else begin
            o_start_pulse <= start_req && !start_err;
            if (wr_en && (i_paddr == REG_CTRL)) begin
                irq_en <= i_pwdata[1];
            end
            if (wr_en && (i_paddr == REG_SRC)) begin
                o_src_addr <= i_pwdata[AXI_AW-1:0];
            end
            if (wr_en && (i_paddr == REG_NUM)) begin
                o_beat_num <= i_pwdata[BUF_AW:0];
            end
            // sticky bits, a new event wins over the clear
            if (i_done_pulse) begin
                done_q <= 1'b1;
            end else if (wr_en && (i_paddr == REG_STATUS) && i_pwdata[1]) begin
                done_q <= 1'b0;
            end
            if (i_err_pulse) begin
                err_q <= 1'b1;
            end else if (wr_en && (i_paddr == REG_STATUS) && i_pwdata[2]) begin
                err_q <= 1'b0;
            end
            // level irq, one cycle behind done
            o_irq <= done_q && irq_en;
        end
    end

    // a completing transfer had its setup phase the cycle before
    a_pready_psel: assert property (@(posedge aclk) disable iff (i_rst)
        o_pready |-> i_psel && $past(i_psel));

endmodule

`default_nettype wire

// File: verilog/idma_top.sv
`timescale 1ns/1ps
`default_nettype none

module idma_top #(
    parameter int AXI_AW    = 32,
    parameter int ID_WIDTH  = 8,
    parameter int BUF_AW    = 6,
    parameter int MAX_BURST = 16
) (
    input  logic                         aclk,
    input  logic                         i_rst,
    // apb config slave
    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic                         i_pwrite,
    input  logic [idma_pkg::APB_AW-1:0]  i_paddr,
    input  idma_pkg::word_t              i_pwdata,
    output logic                         o_pready,
    output idma_pkg::word_t              o_prdata,
    output logic                         o_pslverr,
    // axi read master
    output logic                         o_arvalid,
    output logic [ID_WIDTH-1:0]          o_arid,
    output logic [AXI_AW-1:0]            o_araddr,
    output logic [7:0]                   o_arlen,
    output logic [2:0]                   o_arsize,
    output logic [1:0]                   o_arburst,
    input  logic                         i_arready,
    input  logic                         i_rvalid,
    input  idma_pkg::word_t              i_rdata,
    input  logic [1:0]                   i_rresp,
    input  logic                         i_rlast,
    output logic                         o_rready,
    output logic                         o_irq
);
    import idma_pkg::*;

    // regfile <-> engine
    logic              start_pulse;
    logic [AXI_AW-1:0] src_addr;
    logic [BUF_AW:0]   beat_num;
    logic              busy;
    logic              done_pulse;
    logic              err_pulse;
    // buffer ports
    logic              buf_we;
    logic [BUF_AW-1:0] buf_waddr;
    word_t             buf_wdata;
    logic              buf_re;
    logic [BUF_AW-1:0] buf_raddr;
    word_t             buf_rdata;

    // ========================================
    // config registers
    // ========================================
    idma_regfile #(
        .AXI_AW (AXI_AW),
        .BUF_AW (BUF_AW)
    ) u_regfile (
        .aclk          (aclk),
        .i_rst         (i_rst),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_pready      (o_pready),
        .o_prdata      (o_prdata),
        .o_pslverr     (o_pslverr),
        .i_busy        (busy),
        .i_done_pulse  (done_pulse),
        .i_err_pulse   (err_pulse),
        .o_start_pulse (start_pulse),
        .o_src_addr    (src_addr),
        .o_beat_num    (beat_num),
        .o_buf_re      (buf_re),
        .o_buf_raddr   (buf_raddr),
        .i_buf_rdata   (buf_rdata),
        .o_irq         (o_irq)
    );

    // ========================================
    // read engine
    // ========================================
    idma_rd_engine #(
        .AXI_AW    (AXI_AW),
        .ID_WIDTH  (ID_WIDTH),
        .BUF_AW    (BUF_AW),
        .MAX_BURST (MAX_BURST)
    ) u_rd_engine (
        .aclk          (aclk),
        .i_rst         (i_rst),
        .i_start_pulse (start_pulse),
        .i_src_addr    (src_addr),
        .i_beat_num    (beat_num),
        .o_busy        (busy),
        .o_done_pulse  (done_pulse),
        .o_err_pulse   (err_pulse),
        .o_arvalid     (o_arvalid),
        .o_arid        (o_arid),
        .o_araddr      (o_araddr),
        .o_arlen       (o_arlen),
        .o_arsize      (o_arsize),
        .o_arburst     (o_arburst),
        .i_arready     (i_arready),
        .i_rvalid      (i_rvalid),
        .i_rdata       (i_rdata),
        .i_rresp       (i_rresp),
        .i_rlast       (i_rlast),
        .o_rready      (o_rready),
        .o_buf_we      (buf_we),
        .o_buf_waddr   (buf_waddr),
        .o_buf_wdata   (buf_wdata)
    );

    // ========================================
    // on-chip buffer
    // ========================================
    idma_buffer #(
        .BUF_AW (BUF_AW)
    ) u_buffer (
        .aclk    (aclk),
        .i_we    (buf_we),
        .i_waddr (buf_waddr),
        .i_wdata (buf_wdata),
        .i_re    (buf_re),
        .i_raddr (buf_raddr),
        .o_rdata (buf_rdata)
    );

endmodule

`default_nettype wire
